/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -j 0 --top-module sc_tb_top -f src.f -o sc_tb_sim \
  && ./obj_dir/sc_tb_sim > sim.log 2>&1 \
  || { echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "STATUS: PASS" sim.log || exit 1

/* source/axil_pkg.sv */
`default_nettype none

package axil_pkg;

  typedef logic [3:0]  axil_addr_t;  // byte offset into the register map
  typedef logic [31:0] axil_data_t;
  typedef logic [1:0]  axil_resp_t;

  localparam axil_resp_t AXIL_OKAY   = 2'b00;
  localparam axil_resp_t AXIL_SLVERR = 2'b10;

  // register map
  localparam axil_addr_t REG_CTRL     = 4'h0;  // [0] start (wo), [1] op
  localparam axil_addr_t REG_OPERANDS = 4'h4;  // [3:0] a, [7:4] b
  localparam axil_addr_t REG_STATUS   = 4'h8;  // [0] busy, [1] done
  localparam axil_addr_t REG_RESULT   = 4'hC;  // [7:0] ones count

  // master driven
  typedef struct packed {
    axil_addr_t awaddr;
    logic       awvalid;
    axil_data_t wdata;
    logic       wvalid;
    logic       bready;
    axil_addr_t araddr;
    logic       arvalid;
    logic       rready;
  } axil_req_t;

  // slave driven
  typedef struct packed {
    logic       awready;
    logic       wready;
    axil_resp_t bresp;
    logic       bvalid;
    logic       arready;
    axil_data_t rdata;
    axil_resp_t rresp;
    logic       rvalid;
  } axil_rsp_t;

endpackage

`default_nettype wire

/* source/axil_regs.sv */
`default_nettype none

module axil_regs
  import sc_pkg::*;
  import axil_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  axil_req_t    req,
  output axil_rsp_t    rsp,
  output core_cmd_t    cmd,
  input  core_status_t status
);

  logic       wr_fire;
  logic       rd_fire;
  logic       bvalid_q;
  logic       rvalid_q;
  axil_data_t rdata_q;
  axil_data_t rd_word;

  logic       start_q;
  sc_op_e     op_q;
  operand_t   a_q;
  operand_t   b_q;

  // aw and w are taken together, never one alone
  assign wr_fire = req.awvalid & req.wvalid & ~bvalid_q;
  assign rd_fire = req.arvalid & ~rvalid_q;

  // write response
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      bvalid_q <= 1'b0;
    end else if (wr_fire) begin
      bvalid_q <= 1'b1;
    end else if (req.bready) begin
      bvalid_q <= 1'b0;
    end
  end

  // register writes, read-only and unmapped offsets fall through
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      op_q <= SC_OP_MUL;
      a_q  <= '0;
      b_q  <= '0;
    end else if (wr_fire) begin
      case (req.awaddr)
        REG_CTRL: op_q <= sc_op_e'(req.wdata[1]);
        REG_OPERANDS: begin
          a_q <= req.wdata[3:0];
          b_q <= req.wdata[7:4];
        end
        default: ;
      endcase
    end
  end

  // start pulse, high for the cycle after the CTRL write
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      start_q <= 1'b0;
    end else begin
      start_q <= wr_fire & (req.awaddr == REG_CTRL) & req.wdata[0];
    end
  end

  always_comb begin
    case (req.araddr)
      REG_CTRL:     rd_word = {30'd0, op_q, 1'b0};  // start never reads back
      REG_OPERANDS: rd_word = {24'd0, b_q, a_q};
      REG_STATUS:   rd_word = {30'd0, status.done, status.busy};
      REG_RESULT:   rd_word = {24'd0, status.result};
      default:      rd_word = '0;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rvalid_q <= 1'b0;
    end else if (rd_fire) begin
      rvalid_q <= 1'b1;
    end else if (req.rready) begin
      rvalid_q <= 1'b0;
    end
  end

  // captured at the handshake, stable until rready
  always_ff @(posedge clk) begin
    if (rd_fire) begin
      rdata_q <= rd_word;
    end
  end

  always_comb begin
    rsp.awready = ~bvalid_q & ~(req.awvalid & ~req.wvalid);
    rsp.wready  = ~bvalid_q & ~(req.wvalid & ~req.awvalid);
    rsp.bresp   = AXIL_OKAY;
    rsp.bvalid  = bvalid_q;
    rsp.arready = ~rvalid_q;
    rsp.rdata   = rdata_q;
    rsp.rresp   = AXIL_OKAY;
    rsp.rvalid  = rvalid_q;
  end

  assign cmd.start = start_q;
  assign cmd.op    = op_q;
  assign cmd.a     = a_q;
  assign cmd.b     = b_q;

endmodule

`default_nettype wire

/* source/magnitude_comparator.sv */
`default_nettype none

module magnitude_comparator
  import sc_pkg::*;
(
  input  operand_t a,
  input  operand_t b,
  output logic     a_gt_b
);

  logic [3:0] bit_eq;     // per-bit equal
  logic [3:0] bit_gt;     // per-bit a larger
  logic       eq_above;   // all higher bits equal so far
  logic       gt_found;

  // 1-bit cells
  always_comb begin
    bit_eq = (a & b) | (~a & ~b);
    bit_gt = a & ~b;
  end

  // priority from msb down, a lower bit only counts if every bit above matched
  always_comb begin
    eq_above = 1'b1;
    gt_found = 1'b0;
    for (int i = 3; i >= 0; i--) begin
      gt_found = gt_found | (eq_above & bit_gt[i]);
      eq_above = eq_above & bit_eq[i];
    end
  end

  assign a_gt_b = gt_found;

endmodule

`default_nettype wire

/* source/ramp_counter.sv */
`default_nettype none

module ramp_counter
  import sc_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     clear,
  input  logic     en,
  output operand_t count,
  output logic     carry
);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      count <= '0;
    end else if (clear) begin
      count <= '0;
    end else if (en) begin
      count <= count + 1'b1;  // wraps 15 -> 0
    end
  end

  // terminal count, same cycle as the wrap so the next stage steps in step
  assign carry = en & (&count);

endmodule

`default_nettype wire

/* source/sc_accel_top.sv */
`default_nettype none

module sc_accel_top
  import sc_pkg::*;
  import axil_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  axil_req_t req,
  output axil_rsp_t rsp
);

  core_cmd_t    core_cmd;     // regs -> core
  core_status_t core_status;  // core -> regs

  // bus side
  axil_regs u_regs (
    .clk    (clk),
    .rst    (rst),
    .req    (req),
    .rsp    (rsp),
    .cmd    (core_cmd),
    .status (core_status)
  );

  // stochastic datapath
  stoch_core u_core (
    .clk    (clk),
    .rst    (rst),
    .cmd    (core_cmd),
    .status (core_status)
  );

endmodule

`default_nettype wire

/* source/sc_pkg.sv */
`default_nettype none

package sc_pkg;

  // one frame visits every (fast, slow) ramp pair once, 16 x 16
  localparam int FRAME_CYCLES = 256;

  // operand value, also used for the ramp counters
  typedef logic [3:0] operand_t;

  // ones count over one frame
  typedef logic [$clog2(FRAME_CYCLES)-1:0] count_t;

  typedef enum logic {
    SC_OP_MUL        = 1'b0,  // AND of the two streams
    SC_OP_SCALED_ADD = 1'b1   // 2:1 mux, select from fast ramp lsb
  } sc_op_e;

  typedef enum logic [1:0] {
    CORE_IDLE,
    CORE_RUN,
    CORE_DONE
  } core_state_e;

  // register block to core
  typedef struct packed {
    logic     start;  // single-cycle pulse
    sc_op_e   op;
    operand_t a;
    operand_t b;
  } core_cmd_t;

  // core back to register block
  typedef struct packed {
    logic   busy;
    logic   done;
    count_t result;
  } core_status_t;

endpackage

`default_nettype wire

/* source/stoch_core.sv */
`default_nettype none

module stoch_core
  import sc_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  core_cmd_t    cmd,
  output core_status_t status
);

  core_state_e state;
  logic        running;
  logic        start_accept;
  logic        frame_end;

  sc_op_e      op_q;   // frame operands, held for the whole run
  operand_t    a_q;
  operand_t    b_q;

  logic        stream_a;
  logic        stream_b;
  logic        stream_y;
  logic        fast_carry;
  logic        slow_carry;
  operand_t    fast_ramp;
  count_t      ones_q;

  assign running      = (state == CORE_RUN);
  assign start_accept = cmd.start & ~running;  // start during RUN is dropped
  assign frame_end    = fast_carry & slow_carry;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= CORE_IDLE;
    end else begin
      case (state)
        CORE_IDLE, CORE_DONE: if (start_accept) state <= CORE_RUN;
        CORE_RUN:             if (frame_end) state <= CORE_DONE;
        default:              state <= CORE_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start_accept) begin
      op_q <= cmd.op;
      a_q  <= cmd.a;
      b_q  <= cmd.b;
    end
  end

  // fast ramp steps every run cycle
  stoch_number_gen u_sng_fast (
    .clk    (clk),
    .rst    (rst),
    .clear  (start_accept),
    .en     (running),
    .value  (a_q),
    .stream (stream_a),
    .carry  (fast_carry),
    .ramp   (fast_ramp)
  );

  // slow ramp steps once per fast wrap
  stoch_number_gen u_sng_slow (
    .clk    (clk),
    .rst    (rst),
    .clear  (start_accept),
    .en     (fast_carry),
    .value  (b_q),
    .stream (stream_b),
    .carry  (slow_carry),
    .ramp   ()
  );

  always_comb begin
    if (op_q == SC_OP_MUL) begin
      stream_y = stream_a & stream_b;
    end else begin
      stream_y = fast_ramp[0] ? stream_b : stream_a;  // even f picks a
    end
  end

  // stochastic back to binary
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ones_q <= '0;
    end else if (start_accept) begin
      ones_q <= '0;
    end else if (running) begin
      ones_q <= ones_q + count_t'(stream_y);
    end
  end

  assign status.busy   = running;
  assign status.done   = (state == CORE_DONE);
  assign status.result = ones_q;

endmodule

`default_nettype wire

/* source/stoch_number_gen.sv */
`default_nettype none

module stoch_number_gen
  import sc_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     clear,
  input  logic     en,
  input  operand_t value,
  output logic     stream,
  output logic     carry,
  output operand_t ramp
);

  // deterministic ramp instead of a random source
  ramp_counter u_ramp (
    .clk   (clk),
    .rst   (rst),
    .clear (clear),
    .en    (en),
    .count (ramp),
    .carry (carry)
  );

  // stream bit is 1 for value of the 16 ramp steps
  magnitude_comparator u_cmp (
    .a      (value),
    .b      (ramp),
    .a_gt_b (stream)
  );

endmodule

`default_nettype wire

/* src.f */
+incdir+testbench
source/sc_pkg.sv
source/axil_pkg.sv
source/ramp_counter.sv
source/magnitude_comparator.sv
source/stoch_number_gen.sv
source/stoch_core.sv
source/axil_regs.sv
source/sc_accel_top.sv
testbench/sc_tb_top.sv

/* testbench/sc_tb_bus.svh */
`ifndef SC_TB_BUS_SVH
`define SC_TB_BUS_SVH

// next value of the 32-bit xorshift sequence
function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] y;
  y = x ^ (x << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

function automatic int mul_model(input int a, input int b);
  return a * b;  // ones where both streams are high
endfunction

// even fast steps pass stream a, odd steps pass stream b
function automatic int scaled_add_model(input int a, input int b);
  return 16 * ((a + 1) / 2) + 8 * b;
endfunction

task automatic check_equal(input string what, input int expected, input int actual);
  assert (actual == expected) else begin
    $display("error %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
    errors++;
  end
endtask

task automatic note_failure(input string msg);
  $display("%s in test %s", msg, test_name);
  errors++;
endtask

// aw and w together, response held for hold cycles with bready low
task automatic axil_write(input axil_addr_t addr, input axil_data_t data, input int hold);
  @(posedge clk);
  req.awaddr  <= addr;
  req.awvalid <= 1'b1;
  req.wdata   <= data;
  req.wvalid  <= 1'b1;
  req.bready  <= 1'b0;
  @(negedge clk);
  while (!(rsp.awready && rsp.wready)) @(negedge clk);
  @(posedge clk);  // handshake edge
  req.awvalid <= 1'b0;
  req.wvalid  <= 1'b0;
  @(negedge clk);
  while (!rsp.bvalid) @(negedge clk);
  check_equal("bresp", int'(AXIL_OKAY), int'(rsp.bresp));
  repeat (hold) begin
    @(negedge clk);
    assert (rsp.bvalid) else note_failure("write response not held for bready");
    assert (!rsp.awready && !rsp.wready)
      else note_failure("write channel open while a response was pending");
  end
  @(posedge clk);
  req.bready <= 1'b1;
  @(posedge clk);  // response taken here
  req.bready <= 1'b0;
  @(negedge clk);
  assert (!rsp.bvalid) else note_failure("write response still pending after bready");
endtask

// rdata must not move while rready is low
task automatic axil_read(input axil_addr_t addr, input int hold, output axil_data_t data);
  @(posedge clk);
  req.araddr  <= addr;
  req.arvalid <= 1'b1;
  req.rready  <= 1'b0;
  @(negedge clk);
  while (!rsp.arready) @(negedge clk);
  @(posedge clk);
  req.arvalid <= 1'b0;
  @(negedge clk);
  while (!rsp.rvalid) @(negedge clk);
  data = rsp.rdata;
  check_equal("rresp", int'(AXIL_OKAY), int'(rsp.rresp));
  repeat (hold) begin
    @(negedge clk);
    assert (rsp.rvalid) else note_failure("read response dropped before rready");
    assert (!rsp.arready)
      else note_failure("read address open while a response was pending");
    check_equal("rdata held", int'(data), int'(rsp.rdata));
  end
  @(posedge clk);
  req.rready <= 1'b1;
  @(posedge clk);
  req.rready <= 1'b0;
endtask

`endif

/* testbench/sc_tb_top.sv */
`default_nettype none

module sc_tb_top
  import sc_pkg::*;
  import axil_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 40 * 300;  // 40 frames with bus overhead

  logic        clk;
  logic        rst;
  axil_req_t   req;
  axil_rsp_t   rsp;

  int          errors = 0;
  int          errors_at_start = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  int          cycle_count = 0;
  string       test_name;
  logic [31:0] rng_state;

  `include "sc_tb_bus.svh"

  sc_accel_top u_dut (
    .clk (clk),
    .rst (rst),
    .req (req),
    .rsp (rsp)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, the DUT stopped responding", cycle_count);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  task automatic start_test(input string name);
    test_name = name;
    errors_at_start = errors;
  endtask

  task automatic finish_test();
    if (errors == errors_at_start) begin
      tests_passed++;
      $display("test %s: ok", test_name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", test_name, errors - errors_at_start);
    end
  endtask

  task automatic start_frame(input sc_op_e op, input operand_t a, input operand_t b);
    axil_write(REG_OPERANDS, {24'd0, b, a}, 0);
    axil_write(REG_CTRL, {30'd0, op, 1'b1}, 0);
  endtask

  // poll until the done bit shows up
  task automatic wait_done();
    axil_data_t word;
    word = '0;
    while (!word[1]) axil_read(REG_STATUS, 0, word);
  endtask

  task automatic check_frame(input sc_op_e op, input operand_t a, input operand_t b);
    axil_data_t word;
    int         expected;
    if (op == SC_OP_MUL) expected = mul_model(int'(a), int'(b));
    else expected = scaled_add_model(int'(a), int'(b));
    start_frame(op, a, b);
    wait_done();
    axil_read(REG_RESULT, 0, word);
    check_equal($sformatf("result a=%0d b=%0d", a, b), expected, int'(word));
  endtask

  task automatic check_corners_and_random(input sc_op_e op);
    check_frame(op, 4'd0, 4'd9);
    check_frame(op, 4'd9, 4'd0);
    check_frame(op, 4'd15, 4'd15);
    check_frame(op, 4'd15, 4'd1);
    for (int i = 0; i < 8; i++) begin
      rng_state = xorshift32(rng_state);
      check_frame(op, rng_state[3:0], rng_state[7:4]);
    end
  endtask

  initial begin
    axil_data_t word;
    rng_state = 32'hef14;
    rst <= 1'b1;
    req <= '0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;

    start_test("reset");
    axil_read(REG_STATUS, 0, word);
    check_equal("status", 0, int'(word));
    axil_read(REG_RESULT, 0, word);
    check_equal("result", 0, int'(word));
    axil_read(REG_CTRL, 0, word);
    check_equal("ctrl", 0, int'(word));
    finish_test();

    start_test("multiply");
    check_corners_and_random(SC_OP_MUL);
    finish_test();

    start_test("scaled_add");
    check_corners_and_random(SC_OP_SCALED_ADD);
    axil_read(REG_CTRL, 0, word);
    check_equal("ctrl op", 2, int'(word));  // op reads back, start does not
    finish_test();

    start_test("frame_control");
    start_frame(SC_OP_MUL, 4'd13, 4'd11);
    axil_read(REG_STATUS, 0, word);
    check_equal("status in run", 1, int'(word));
    axil_write(REG_CTRL, 32'h1, 0);  // ignored, frame in progress
    axil_write(REG_OPERANDS, {24'd0, 4'd2, 4'd3}, 0);
    wait_done();
    axil_read(REG_RESULT, 0, word);
    check_equal("result", mul_model(13, 11), int'(word));
    axil_read(REG_STATUS, 0, word);
    check_equal("status after done", 2, int'(word));
    axil_write(REG_CTRL, 32'h1, 0);
    axil_read(REG_STATUS, 0, word);
    check_equal("status after restart", 1, int'(word));
    wait_done();
    axil_read(REG_RESULT, 0, word);
    check_equal("restart result", mul_model(3, 2), int'(word));
    finish_test();

    start_test("bus");
    axil_write(REG_OPERANDS, 32'h0000_005a, 5);
    axil_read(REG_OPERANDS, 0, word);
    check_equal("operands", 32'h5a, int'(word));
    axil_write(REG_STATUS, 32'hffff_ffff, 0);
    axil_read(REG_STATUS, 0, word);
    check_equal("status", 2, int'(word));
    axil_write(REG_RESULT, 32'hffff_ffff, 0);
    axil_read(REG_RESULT, 6, word);
    check_equal("result", mul_model(3, 2), int'(word));
    axil_write(4'h2, 32'hffff_ffff, 0);  // unaligned, no register there
    axil_read(4'h2, 0, word);
    check_equal("unmapped", 0, int'(word));
    axil_read(REG_CTRL, 0, word);
    check_equal("ctrl", 0, int'(word));
    finish_test();

    $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
